// File: common/cdb_pkg.sv
package cdb_pkg;

  // ------------------------------------------------------------------------
  // Sizes
  // ------------------------------------------------------------------------

  // Ordinary execution units, served in rounds
  localparam int unsigned NUM_EU = 4;

  // Index of an ordinary unit on the arbiter/mux side
  localparam int unsigned EU_IDX_W = $clog2(NUM_EU);

  // ROB tag and result value
  localparam int unsigned ROB_IDX_W = 4;
  localparam int unsigned DATA_W = 32;

  // ------------------------------------------------------------------------
  // Exception codes
  // ------------------------------------------------------------------------

  // Reported by the unit together with the result, resolved at commit
  typedef enum logic [1:0] {
    EXC_NONE         = 2'd0,
    EXC_MISALIGNED   = 2'd1,
    EXC_ILLEGAL      = 2'd2,
    EXC_ACCESS_FAULT = 2'd3
  } except_e;

  // ------------------------------------------------------------------------
  // Result and bus words
  // ------------------------------------------------------------------------

  // One finished result as produced by an execution unit
  typedef struct packed {
    logic [ROB_IDX_W-1:0] rob_idx;
    logic [DATA_W-1:0]    value;
    except_e              exc;
  } eu_result_t;

  // Word driven on the CDB towards the ROB
  // Max_prio marks results coming from the dedicated line
  typedef struct packed {
    logic       max_prio;
    eu_result_t res;
  } cdb_word_t;

endpackage

// File: rtl/eu_result_buffer.sv
`timescale 1ns/10ps

module eu_result_buffer (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,

  // From the execution unit
  input  logic                res_valid_i,
  input  cdb_pkg::eu_result_t res_i,
  output logic                busy_o,

  // To the arbiter and the CDB mux
  output logic                valid_o,
  input  logic                ready_i,
  output cdb_pkg::eu_result_t data_o
);

  // Entry state
  logic                valid_q;
  cdb_pkg::eu_result_t data_q;

  // Entry handed over to the CDB at this edge
  logic                pop;

  assign pop = valid_q & ready_i;

  // ------------------------------------------------------------------------
  // Entry registers
  // ------------------------------------------------------------------------

  // A new strobe wins over a pop, so a refill at the accepting edge keeps it full
  always_ff @(posedge clk_i or negedge rst_ni) begin : valid_reg
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (res_valid_i) begin
      valid_q <= 1'b1;
    end else if (pop) begin
      valid_q <= 1'b0;
    end
  end

  // Payload, loaded on every accepted strobe
  always_ff @(posedge clk_i) begin : data_reg
    if (res_valid_i && !flush_i) begin
      data_q <= res_i;
    end
  end

  // Unit stalls on a full entry
  assign busy_o  = valid_q;
  assign valid_o = valid_q;
  assign data_o  = data_q;

  // The unit must honour busy_o, a refill is only legal at the accepting edge
  a_no_overwrite : assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
    res_valid_i |-> (!valid_q || ready_i))
    else $error("eu_result_buffer: result strobed into a full entry");

endmodule

// File: cdb/cdb_arbiter.sv
`timescale 1ns/10ps

module cdb_arbiter (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         flush_i,

  // Dedicated maximum-priority line
  input  logic                         max_prio_valid_i,
  output logic                         max_prio_ready_o,

  // Ordinary units
  input  logic [cdb_pkg::NUM_EU-1:0]   valid_i,
  output logic [cdb_pkg::NUM_EU-1:0]   ready_o,

  // ROB side
  input  logic                         rob_ready_i,
  output logic                         rob_valid_o,

  // Select lines for the CDB mux
  output logic                         served_max_prio_o,
  output logic [cdb_pkg::EU_IDX_W-1:0] served_idx_o
);

  // Remaining requests of the current round
  logic [cdb_pkg::NUM_EU-1:0]   rem_valid_q;
  logic [cdb_pkg::NUM_EU-1:0]   rem_valid_d;

  // Candidates, encoder and one-hot grant
  logic [cdb_pkg::NUM_EU-1:0]   cand;
  logic [cdb_pkg::EU_IDX_W-1:0] enc_idx;
  logic                         enc_valid;
  logic [cdb_pkg::NUM_EU-1:0]   grant;

  // ------------------------------------------------------------------------
  // Candidate selection
  // ------------------------------------------------------------------------

  // New requests wait while the round is still open
  assign cand = (|rem_valid_q) ? rem_valid_q : valid_i;

  // Lowest index first
  always_comb begin : prio_enc
    enc_idx   = '0;
    enc_valid = 1'b0;
    for (int i = cdb_pkg::NUM_EU - 1; i >= 0; i--) begin
      if (cand[i]) begin
        enc_idx   = i[cdb_pkg::EU_IDX_W-1:0];
        enc_valid = 1'b1;
      end
    end
  end

  always_comb begin : grant_dec
    grant = '0;
    if (enc_valid) begin
      grant[enc_idx] = 1'b1;
    end
  end

  // ------------------------------------------------------------------------
  // Handshake outputs
  // ------------------------------------------------------------------------
  assign rob_valid_o      = max_prio_valid_i | enc_valid;
  assign max_prio_ready_o = max_prio_valid_i & rob_ready_i;
  assign ready_o          = (!max_prio_valid_i && rob_ready_i) ? grant : '0;

  // Max-priority line overrides the ordinary index
  assign served_max_prio_o = max_prio_valid_i;
  assign served_idx_o      = enc_idx;

  // ------------------------------------------------------------------------
  // Round snapshot
  // ------------------------------------------------------------------------

  // Held while the max-priority line owns the bus
  // A stalled ordinary transfer freezes the candidate set, so the word stays put
  always_comb begin : rem_next
    if (max_prio_valid_i) begin
      rem_valid_d = rem_valid_q;
    end else begin
      rem_valid_d = cand & ~ready_o;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : rem_reg
    if (!rst_ni) begin
      rem_valid_q <= '0;
    end else if (flush_i) begin
      rem_valid_q <= '0;
    end else begin
      rem_valid_q <= rem_valid_d;
    end
  end

  // ------------------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------------------

  // Snapshot only keeps units whose buffer still holds a result
  a_snap_pending : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rem_valid_q & ~valid_i) == '0)
    else $error("cdb_arbiter: round holds a unit with an empty buffer");

  // Stalled ordinary grant keeps its index until the ROB takes it
  a_stall_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (enc_valid && !max_prio_valid_i && !rob_ready_i && !flush_i) |=>
      (max_prio_valid_i || (enc_valid && $stable(enc_idx))))
    else $error("cdb_arbiter: ordinary grant moved under back-pressure");

endmodule

// File: cdb/cdb_mux.sv
`timescale 1ns/10ps

module cdb_mux (
  // Maximum-priority buffer
  input  cdb_pkg::eu_result_t          max_prio_data_i,

  // Ordinary buffers
  input  cdb_pkg::eu_result_t          eu_data_i [cdb_pkg::NUM_EU],

  // Select lines from the arbiter
  input  logic                         served_max_prio_i,
  input  logic [cdb_pkg::EU_IDX_W-1:0] served_idx_i,

  // Bus word towards the ROB
  output cdb_pkg::cdb_word_t           cdb_o
);

  // Result picked among the ordinary buffers
  cdb_pkg::eu_result_t eu_sel;

  // ------------------------------------------------------------------------
  // Result steering
  // ------------------------------------------------------------------------

  // Index is only meaningful when the arbiter has an ordinary grant
  assign eu_sel = eu_data_i[served_idx_i];

  // Dedicated line takes the bus whenever it is served
  always_comb begin : bus_word
    cdb_o.max_prio = served_max_prio_i;
    if (served_max_prio_i) begin
      cdb_o.res = max_prio_data_i;
    end else begin
      cdb_o.res = eu_sel;
    end
  end

endmodule

// File: rtl/cdb_top.sv
`timescale 1ns/10ps

module cdb_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       flush_i,

  // Maximum-priority execution unit
  input  logic                       mp_res_valid_i,
  input  cdb_pkg::eu_result_t        mp_res_i,
  output logic                       mp_busy_o,

  // Ordinary execution units
  input  logic [cdb_pkg::NUM_EU-1:0] eu_res_valid_i,
  input  cdb_pkg::eu_result_t        eu_res_i [cdb_pkg::NUM_EU],
  output logic [cdb_pkg::NUM_EU-1:0] eu_busy_o,

  // ROB side
  input  logic                       rob_ready_i,
  output logic                       cdb_valid_o,
  output cdb_pkg::cdb_word_t         cdb_o
);

  // Maximum-priority buffer to arbiter and mux
  logic                         mp_valid;
  logic                         mp_ready;
  cdb_pkg::eu_result_t          mp_data;

  // Ordinary buffers to arbiter and mux
  logic [cdb_pkg::NUM_EU-1:0]   eu_valid;
  logic [cdb_pkg::NUM_EU-1:0]   eu_ready;
  cdb_pkg::eu_result_t          eu_data [cdb_pkg::NUM_EU];

  // Arbiter select lines
  logic                         served_max_prio;
  logic [cdb_pkg::EU_IDX_W-1:0] served_idx;

  // ------------------------------------------------------------------------
  // Result buffers
  // ------------------------------------------------------------------------
  eu_result_buffer u_mp_buf (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (flush_i),
    .res_valid_i(mp_res_valid_i),
    .res_i      (mp_res_i),
    .busy_o     (mp_busy_o),
    .valid_o    (mp_valid),
    .ready_i    (mp_ready),
    .data_o     (mp_data)
  );

  for (genvar i = 0; i < cdb_pkg::NUM_EU; i++) begin : gen_eu_buf
    eu_result_buffer u_eu_buf (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .flush_i    (flush_i),
      .res_valid_i(eu_res_valid_i[i]),
      .res_i      (eu_res_i[i]),
      .busy_o     (eu_busy_o[i]),
      .valid_o    (eu_valid[i]),
      .ready_i    (eu_ready[i]),
      .data_o     (eu_data[i])
    );
  end

  // ------------------------------------------------------------------------
  // Arbitration and bus datapath
  // ------------------------------------------------------------------------
  cdb_arbiter u_arbiter (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_i          (flush_i),
    .max_prio_valid_i (mp_valid),
    .max_prio_ready_o (mp_ready),
    .valid_i          (eu_valid),
    .ready_o          (eu_ready),
    .rob_ready_i      (rob_ready_i),
    .rob_valid_o      (cdb_valid_o),
    .served_max_prio_o(served_max_prio),
    .served_idx_o     (served_idx)
  );

  cdb_mux u_mux (
    .max_prio_data_i  (mp_data),
    .eu_data_i        (eu_data),
    .served_max_prio_i(served_max_prio),
    .served_idx_i     (served_idx),
    .cdb_o            (cdb_o)
  );

endmodule

// File: tb/tb_clkgen.sv
`timescale 1ns/10ps

module tb_clkgen (
  output logic clk_o,
  output logic rst_no
);

  // 8 ns period
  initial begin : clock
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Reset held for 16 cycles, released away from the rising edge
  initial begin : reset
    rst_no = 1'b0;
    repeat (16) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// File: tb/cdb_tb.sv
`timescale 1ns/10ps

module cdb_tb;

  localparam int          NUM_STROBES = 200;
  localparam int unsigned CYCLE_LIMIT = NUM_STROBES * 8 + 200;

  logic                       clk;
  logic                       rst_n;
  logic                       flush;
  logic                       mp_res_valid;
  cdb_pkg::eu_result_t        mp_res;
  logic                       mp_busy;
  logic [cdb_pkg::NUM_EU-1:0] eu_res_valid;
  cdb_pkg::eu_result_t        eu_res [cdb_pkg::NUM_EU];
  logic [cdb_pkg::NUM_EU-1:0] eu_busy;
  logic                       rob_ready;
  logic                       cdb_valid;
  cdb_pkg::cdb_word_t         cdb_word;

  // Reference model state
  logic                       m_mp_valid;
  cdb_pkg::eu_result_t        m_mp_data;
  logic [cdb_pkg::NUM_EU-1:0] m_valid;
  cdb_pkg::eu_result_t        m_data [cdb_pkg::NUM_EU];
  logic [cdb_pkg::NUM_EU-1:0] m_snap;
  logic [15:0]                tag_out;

  // Model prediction for the current cycle
  logic [cdb_pkg::NUM_EU-1:0] ord_req;
  logic                       ord_hit;
  int                         ord_idx;
  logic                       exp_valid;
  cdb_pkg::cdb_word_t         exp_word;

  logic [15:0]                lfsr_q;
  logic [cdb_pkg::ROB_IDX_W-1:0] next_tag;
  int                         strobes;
  int                         next_flush;
  int unsigned                cycles = 0;

  tb_clkgen u_clkgen (.clk_o(clk), .rst_no(rst_n));

  cdb_top UUT (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .flush_i       (flush),
    .mp_res_valid_i(mp_res_valid),
    .mp_res_i      (mp_res),
    .mp_busy_o     (mp_busy),
    .eu_res_valid_i(eu_res_valid),
    .eu_res_i      (eu_res),
    .eu_busy_o     (eu_busy),
    .rob_ready_i   (rob_ready),
    .cdb_valid_o   (cdb_valid),
    .cdb_o         (cdb_word)
  );

  // ------------------------------------------------------------------------
  // Random source and result generation
  // ------------------------------------------------------------------------

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    lfsr_step = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  // Fresh tag, random value and exception code
  task automatic make_result(output cdb_pkg::eu_result_t r);
    logic [31:0] v;
    r.rob_idx = next_tag;
    next_tag = next_tag + 1'b1;
    take_bits(32, v);
    r.value = v;
    take_bits(2, v);
    r.exc = cdb_pkg::except_e'(v[1:0]);
  endtask

  task automatic report_mismatch(input string what);
    $display("mismatch at %0t: %s", $time, what);
    $display("Errors found");
    $fatal(1);
  endtask

  // ------------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------------

  // Open round first, else every pending ordinary unit; lowest index wins
  always_comb begin : predict
    ord_req = (|m_snap) ? m_snap : m_valid;
    ord_hit = 1'b0;
    ord_idx = 0;
    for (int i = 0; i < cdb_pkg::NUM_EU; i++) begin
      if (ord_req[i] && !ord_hit) begin
        ord_hit = 1'b1;
        ord_idx = i;
      end
    end
    exp_valid         = m_mp_valid | ord_hit;
    exp_word.max_prio = m_mp_valid;
    exp_word.res      = m_mp_valid ? m_mp_data : m_data[ord_idx];
  end

  always @(posedge clk or negedge rst_n) begin : model_update
    logic [15:0]                tags;
    logic [cdb_pkg::NUM_EU-1:0] valid;
    logic [cdb_pkg::NUM_EU-1:0] snap;
    tags  = tag_out;
    valid = m_valid;
    snap  = m_snap;
    if (!rst_n || flush) begin
      m_mp_valid <= 1'b0;
      m_valid    <= '0;
      m_snap     <= '0;
      tag_out    <= '0;
    end else begin
      if (exp_valid && rob_ready) begin
        tags[exp_word.res.rob_idx] = 1'b0;
      end
      // Max-priority line holds the round, a stall freezes the candidates
      if (!m_mp_valid) begin
        snap = ord_req;
        if (ord_hit && rob_ready) begin
          valid[ord_idx] = 1'b0;
          snap[ord_idx]  = 1'b0;
        end
      end
      m_mp_valid <= (m_mp_valid && !rob_ready) || mp_res_valid;
      if (mp_res_valid) begin
        m_mp_data <= mp_res;
        tags[mp_res.rob_idx] = 1'b1;
      end
      for (int i = 0; i < cdb_pkg::NUM_EU; i++) begin
        if (eu_res_valid[i]) begin
          valid[i] = 1'b1;
          m_data[i] <= eu_res[i];
          tags[eu_res[i].rob_idx] = 1'b1;
        end
      end
      m_valid <= valid;
      m_snap  <= snap;
      tag_out <= tags;
    end
  end

  // ------------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------------
  a_valid : assert property (@(posedge clk) disable iff (!rst_n)
    cdb_valid == exp_valid)
    else report_mismatch("cdb_valid_o differs from the model");

  a_busy : assert property (@(posedge clk) disable iff (!rst_n)
    {mp_busy, eu_busy} == {m_mp_valid, m_valid})
    else report_mismatch("busy_o differs from the modeled buffer fill");

  // Source flag, tag, value and exception in one compare
  a_word : assert property (@(posedge clk) disable iff (!rst_n)
    exp_valid |-> (cdb_word == exp_word))
    else report_mismatch("bus word differs from the modeled source");

  a_tag : assert property (@(posedge clk) disable iff (!rst_n)
    (cdb_valid && rob_ready) |-> tag_out[cdb_word.res.rob_idx])
    else report_mismatch("transferred tag is not outstanding");

  a_hold : assert property (@(posedge clk) disable iff (!rst_n)
    (!rob_ready && cdb_valid && !flush) |=>
      ((cdb_valid && $stable(cdb_word)) || $rose(mp_busy)))
    else report_mismatch("bus word changed under back-pressure");

  a_flush : assert property (@(posedge clk) disable iff (!rst_n)
    flush |=> !cdb_valid)
    else report_mismatch("cdb_valid_o high after flush");

  // Watchdog
  always @(posedge clk) begin : watchdog
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the CDB did not drain within %0d cycles", CYCLE_LIMIT);
      $display("Errors found");
      $fatal(1);
    end
  end

  // ------------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------------
  initial begin : stimulus
    logic [31:0] r;
    lfsr_q       = 16'd88;
    next_tag     = '0;
    strobes      = 0;
    next_flush   = 60;
    flush        = 1'b0;
    mp_res_valid = 1'b0;
    mp_res       = '0;
    eu_res_valid = '0;
    rob_ready    = 1'b0;
    for (int i = 0; i < cdb_pkg::NUM_EU; i++) begin
      eu_res[i] = '0;
    end
    wait (rst_n);
    while (strobes < NUM_STROBES) begin
      @(negedge clk);
      // ROB stalls about a quarter of the time
      take_bits(2, r);
      rob_ready = (r[1:0] != 2'b00);
      flush     = 1'b0;
      if (strobes >= next_flush) begin
        flush      = 1'b1;
        next_flush = next_flush + 80;
      end
      mp_res_valid = 1'b0;
      take_bits(2, r);
      if (!mp_busy && r[1:0] == 2'b00) begin
        make_result(mp_res);
        mp_res_valid = 1'b1;
        strobes++;
      end
      for (int i = 0; i < cdb_pkg::NUM_EU; i++) begin
        eu_res_valid[i] = 1'b0;
        take_bits(1, r);
        if (!eu_busy[i] && r[0]) begin
          make_result(eu_res[i]);
          eu_res_valid[i] = 1'b1;
          strobes++;
        end
      end
    end
    // Drain with the ROB always ready
    @(negedge clk);
    flush        = 1'b0;
    mp_res_valid = 1'b0;
    eu_res_valid = '0;
    rob_ready    = 1'b1;
    while (cdb_valid || mp_busy || (|eu_busy)) begin
      @(negedge clk);
    end
    if (tag_out != '0) begin
      $display("A strobed result never reached the CDB");
      $display("Errors found");
      $fatal(1);
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

// File: cdb.f
common/cdb_pkg.sv
rtl/eu_result_buffer.sv
cdb/cdb_arbiter.sv
cdb/cdb_mux.sv
rtl/cdb_top.sv
tb/tb_clkgen.sv
tb/cdb_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= cdb_tb
FLIST     ?= cdb.f
BUILD_DIR ?= obj_dir
PASS_MSG  := No errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q -x "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
